//--- src/adc_pkg.sv
package adc_pkg;

    // sample format
    localparam int SAMPLE_W = 16;  // bits per serial adc word, msb first

    // board layout
    localparam int N_LANES = 8;    // one data line per adc
    localparam int N_BANKS = 2;    // conv/sclk groups, pot bank and current bank
    localparam int N_AXES  = 4;    // axes per bank

    // lane numbering
    // lanes 0..3 carry pot of axis 1..4, lanes 4..7 carry current of axis 1..4
    localparam int POT_LANE_BASE = 0;
    localparam int CUR_LANE_BASE = N_AXES;

    // default frame timing in clkadc cycles
    localparam int CONV_CYCLES_DEF  = 8;   // conv pulse length
    localparam int FRAME_CYCLES_DEF = 64;  // conv to next conv

endpackage

//--- src/reg_pkg.sv
package reg_pkg;

    // apb bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // address split, channel in [7:4] and offset in [3:0]
    localparam int CHAN_LSB = 4;
    localparam int CHAN_W   = 4;   // channels 0..15
    localparam int OFF_LSB  = 0;
    localparam int OFF_W    = 4;

    // channel map
    localparam logic [CHAN_W-1:0] CHAN_STATUS     = 4'd0;  // frame counter lives here
    localparam logic [CHAN_W-1:0] CHAN_AXIS_FIRST = 4'd1;  // axis 1, axes follow in order

    // offsets inside a channel
    localparam logic [OFF_W-1:0] OFF_ADC_DATA = 4'h0;  // {pot, cur} word
    localparam logic [OFF_W-1:0] OFF_STATUS   = 4'h0;  // frame counter at channel 0

endpackage

//--- src/adc_sequencer.sv
module adc_sequencer
    import adc_pkg::*;
#(
    parameter int CONV_CYCLES  = CONV_CYCLES_DEF,   // conv high time
    parameter int FRAME_CYCLES = FRAME_CYCLES_DEF   // full frame period
) (
    input  logic               clkadc,
    input  logic               rst,
    output logic [N_BANKS-1:0] conv,        // same convert timing on every bank
    output logic [N_BANKS-1:0] sclk,
    output logic               shift_en,    // clock where sclk goes high
    output logic               frame_done   // clock after last shift_en
);

    // frame position counter width
    localparam int POS_W = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;

    // landmarks inside one frame
    localparam logic [POS_W-1:0] POS_LAST    = POS_W'(FRAME_CYCLES - 1);
    localparam logic [POS_W-1:0] SHIFT_START = POS_W'(CONV_CYCLES);
    localparam logic [POS_W-1:0] SHIFT_STOP  = POS_W'(CONV_CYCLES + 2 * SAMPLE_W);

    logic [POS_W-1:0] pos;        // frame clock that the outputs show next
    logic [POS_W-1:0] rel;        // offset into the shift window
    logic             in_conv;
    logic             in_shift;
    logic             sclk_hi;    // odd window slot, sclk high
    logic             conv_q;
    logic             sclk_q;
    logic             shift_q;
    logic             done_q;

    // decode of the next position
    assign rel      = pos - SHIFT_START;
    assign in_conv  = (pos < SHIFT_START);
    assign in_shift = (pos >= SHIFT_START) && (pos < SHIFT_STOP);
    assign sclk_hi  = in_shift && rel[0];   // low, high, low, high ... 16 times

    // position counter, wraps at frame end
    always_ff @(posedge clkadc) begin
        if (rst) begin
            pos <= '0;
        end else if (pos == POS_LAST) begin
            pos <= '0;                       // idle done, next frame
        end else begin
            pos <= pos + 1'b1;
        end
    end

    // registered strobes
    // pos is one ahead of these so the frame opens on the first clock out of reset
    always_ff @(posedge clkadc) begin
        if (rst) begin
            conv_q  <= 1'b0;
            sclk_q  <= 1'b0;
            shift_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            conv_q  <= in_conv;
            sclk_q  <= sclk_hi;
            shift_q <= sclk_hi;                  // shift on the rising sclk clock
            done_q  <= (pos == SHIFT_STOP);      // right after the 16th high slot
        end
    end

    // both banks convert and clock together
    assign conv       = {N_BANKS{conv_q}};
    assign sclk       = {N_BANKS{sclk_q}};
    assign shift_en   = shift_q;
    assign frame_done = done_q;

endmodule

//--- src/adc_lane_shifter.sv
module adc_lane_shifter
    import adc_pkg::*;
(
    input  logic                clkadc,
    input  logic                rst,
    input  logic                miso,          // serial data msb first
    input  logic                shift_en,      // take one bit
    input  logic                frame_done,    // word complete
    output logic [SAMPLE_W-1:0] sample,        // last complete word
    output logic                sample_valid   // one clock with the new word on sample
);

    logic [SAMPLE_W-1:0] shreg;   // word being assembled

    // msb arrives first and ends up on top
    always_ff @(posedge clkadc) begin
        if (shift_en) begin
            shreg <= {shreg[SAMPLE_W-2:0], miso};
        end
    end

    // holding register
    // shreg is free to refill for the next frame once the copy is taken
    always_ff @(posedge clkadc) begin
        if (rst) begin
            sample <= '0;
        end else if (frame_done) begin
            sample <= shreg;
        end
    end

    // valid strobe lines up with the updated sample
    always_ff @(posedge clkadc) begin
        if (rst) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= frame_done;
        end
    end

endmodule

//--- src/adc_reg_file.sv
module adc_reg_file
    import adc_pkg::*;
    import reg_pkg::*;
(
    input  logic                             clkadc,
    input  logic                             rst,
    // lanes from the shifters
    input  logic [N_LANES-1:0][SAMPLE_W-1:0] lane_sample,
    input  logic [N_LANES-1:0]               lane_valid,
    // apb3 slave, read only
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [ADDR_W-1:0]                paddr,
    input  logic [DATA_W-1:0]                pwdata,     // ignored, nothing is writable
    output logic [DATA_W-1:0]                prdata,
    output logic                             pready,
    output logic                             pslverr,
    // motor current feedback for the loops
    output logic [SAMPLE_W-1:0]              cur1,
    output logic [SAMPLE_W-1:0]              cur2,
    output logic [SAMPLE_W-1:0]              cur3,
    output logic [SAMPLE_W-1:0]              cur4
);

    logic [SAMPLE_W-1:0] pot_q [N_AXES];   // pot per axis
    logic [SAMPLE_W-1:0] cur_q [N_AXES];   // current per axis
    logic [DATA_W-1:0]   frame_cnt;        // frames since reset, wraps
    logic [CHAN_W-1:0]   chan;
    logic [OFF_W-1:0]    off;
    logic                access;           // apb access phase
    logic                rd_sel;           // read selected
    logic                stat_hit;

    // address fields
    assign chan = paddr[CHAN_LSB +: CHAN_W];
    assign off  = paddr[OFF_LSB +: OFF_W];

    // frame capture
    // all lane valids fire together, lane 0 stands for the set
    always_ff @(posedge clkadc) begin
        if (rst) begin
            for (int a = 0; a < N_AXES; a++) begin
                pot_q[a] <= '0;
                cur_q[a] <= '0;
            end
        end else if (lane_valid[0]) begin
            for (int a = 0; a < N_AXES; a++) begin
                pot_q[a] <= lane_sample[POT_LANE_BASE + a];
                cur_q[a] <= lane_sample[CUR_LANE_BASE + a];
            end
        end
    end

    // frame counter, counts every capture
    always_ff @(posedge clkadc) begin
        if (rst) begin
            frame_cnt <= '0;
        end else if (lane_valid[0]) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // zero wait state handshake
    assign access  = psel && penable;
    assign pready  = access;              // always ready in access
    assign pslverr = access && pwrite;    // every write is refused

    // read mux
    assign rd_sel   = psel && !pwrite;
    assign stat_hit = (chan == CHAN_STATUS) && (off == OFF_STATUS);

    always_comb begin
        prdata = '0;                      // unmapped reads give zero
        if (rd_sel) begin
            if (stat_hit) begin
                prdata = frame_cnt;
            end
            for (int a = 0; a < N_AXES; a++) begin
                // channel 1..4, pot high half, current low half
                if ((chan == CHAN_AXIS_FIRST + CHAN_W'(a)) && (off == OFF_ADC_DATA)) begin
                    prdata = {pot_q[a], cur_q[a]};
                end
            end
        end
    end

    // direct current taps
    assign cur1 = cur_q[0];
    assign cur2 = cur_q[1];
    assign cur3 = cur_q[2];
    assign cur4 = cur_q[3];

endmodule

//--- src/ctrl_adc.sv
module ctrl_adc
    import adc_pkg::*;
    import reg_pkg::*;
#(
    parameter int CONV_CYCLES  = CONV_CYCLES_DEF,
    parameter int FRAME_CYCLES = FRAME_CYCLES_DEF
) (
    input  logic                clkadc,     // adc clock
    input  logic                rst,
    output logic [N_BANKS-1:0]  sclk,       // serial clock per bank
    output logic [N_BANKS-1:0]  conv,       // convert per bank
    input  logic [N_LANES-1:0]  miso,       // one data line per adc
    // apb slave
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [ADDR_W-1:0]   paddr,
    input  logic [DATA_W-1:0]   pwdata,
    output logic [DATA_W-1:0]   prdata,
    output logic                pready,
    output logic                pslverr,
    // current feedback
    output logic [SAMPLE_W-1:0] cur1,
    output logic [SAMPLE_W-1:0] cur2,
    output logic [SAMPLE_W-1:0] cur3,
    output logic [SAMPLE_W-1:0] cur4
);

    logic                             shift_en;
    logic                             frame_done;
    logic [N_LANES-1:0][SAMPLE_W-1:0] lane_sample;
    logic [N_LANES-1:0]               lane_valid;

    // strobes for both banks
    adc_sequencer #(
        .CONV_CYCLES  (CONV_CYCLES),
        .FRAME_CYCLES (FRAME_CYCLES)
    ) u_seq (
        .clkadc     (clkadc),
        .rst        (rst),
        .conv       (conv),
        .sclk       (sclk),
        .shift_en   (shift_en),
        .frame_done (frame_done)
    );

    // one deserializer per data line
    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        adc_lane_shifter u_shift (
            .clkadc       (clkadc),
            .rst          (rst),
            .miso         (miso[i]),
            .shift_en     (shift_en),
            .frame_done   (frame_done),
            .sample       (lane_sample[i]),
            .sample_valid (lane_valid[i])
        );
    end

    // packing, counter and bus side
    adc_reg_file u_regs (
        .clkadc      (clkadc),
        .rst         (rst),
        .lane_sample (lane_sample),
        .lane_valid  (lane_valid),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .cur1        (cur1),
        .cur2        (cur2),
        .cur3        (cur3),
        .cur4        (cur4)
    );

endmodule

//--- bench/adc_model.sv
module adc_model
    import adc_pkg::*;
(
    input  logic [N_BANKS-1:0]               sclk,      // serial clock per bank
    input  logic [N_BANKS-1:0]               conv,      // convert per bank
    input  logic [N_LANES-1:0][SAMPLE_W-1:0] lane_val,  // value each adc converts next
    output logic [N_LANES-1:0]               miso       // serial data, msb first
);

    // one behavioral adc per data line
    for (genvar i = 0; i < N_LANES; i++) begin : g_adc
        localparam int BANK = i / N_AXES;   // lanes 0..3 pot bank, 4..7 current bank

        logic [SAMPLE_W-1:0] word;   // conversion result still to go out
        logic                dout;   // bit on the line

        initial begin
            word = '0;
            dout = 1'b0;
        end

        // conv and sclk never rise together, conv level tells them apart
        always @(posedge conv[BANK] or posedge sclk[BANK]) begin
            if (conv[BANK]) begin
                word <= lane_val[i];                      // conversion takes the value
            end else begin
                dout <= word[SAMPLE_W-1];                 // next bit after the rise
                word <= {word[SAMPLE_W-2:0], 1'b0};
            end
        end

        assign miso[i] = dout;
    end

endmodule

//--- bench/ctrl_adc_checker.sv
module ctrl_adc_checker
    import adc_pkg::*;
(
    input logic               clkadc,
    input logic               rst,
    input logic [N_BANKS-1:0] sclk,
    input logic [N_BANKS-1:0] conv,
    input logic               shift_en,
    input logic               frame_done,
    input logic [N_LANES-1:0] lane_valid,
    input logic               pwrite,
    input logic               pslverr
);

    // shift strobe only inside an sclk high clock
    shift_in_sclk_high: assert property (@(posedge clkadc) disable iff (rst)
        shift_en |-> (&sclk))
        else $error("shift_en seen while sclk is low");

    // end of frame never overlaps the convert window
    done_outside_conv: assert property (@(posedge clkadc) disable iff (rst)
        frame_done |-> !(|conv))
        else $error("frame_done seen while conv is high");

    // lanes share one strobe chain
    lane_valid_equal: assert property (@(posedge clkadc) disable iff (rst)
        (lane_valid == '0) || (lane_valid == '1))
        else $error("lane_valid bits disagree");

    // only a write gets an error response
    slverr_on_write: assert property (@(posedge clkadc) disable iff (rst)
        pslverr |-> pwrite)
        else $error("pslverr raised on a read");

endmodule

// sequencer side, bus and lane inputs tied quiet
bind adc_sequencer ctrl_adc_checker u_seq_chk (
    .clkadc     (clkadc),
    .rst        (rst),
    .sclk       (sclk),
    .conv       (conv),
    .shift_en   (shift_en),
    .frame_done (frame_done),
    .lane_valid ('0),
    .pwrite     (1'b0),
    .pslverr    (1'b0)
);

// register file side, strobe inputs tied quiet
bind adc_reg_file ctrl_adc_checker u_reg_chk (
    .clkadc     (clkadc),
    .rst        (rst),
    .sclk       ('0),
    .conv       ('0),
    .shift_en   (1'b0),
    .frame_done (1'b0),
    .lane_valid (lane_valid),
    .pwrite     (pwrite),
    .pslverr    (pslverr)
);

//--- bench/tb_ctrl_adc.sv
module tb_ctrl_adc
    import adc_pkg::*;
    import reg_pkg::*;
();

    localparam int CONV_CYCLES  = 8;
    localparam int FRAME_CYCLES = 64;
    localparam int RST_CYCLES   = 10;
    localparam int APB_TIMEOUT  = 16;                  // clocks waiting for pready
    localparam int FRAME_POLLS  = 3 * FRAME_CYCLES;    // status reads per frame wait
    localparam int WATCHDOG     = 40 * FRAME_CYCLES * 4;

    logic                             clkadc = 1'b0;
    logic                             rst;
    logic [N_BANKS-1:0]               sclk;
    logic [N_BANKS-1:0]               conv;
    logic [N_LANES-1:0]               miso;
    logic                             psel;
    logic                             penable;
    logic                             pwrite;
    logic [ADDR_W-1:0]                paddr;
    logic [DATA_W-1:0]                pwdata;
    logic [DATA_W-1:0]                prdata;
    logic                             pready;
    logic                             pslverr;
    logic [SAMPLE_W-1:0]              cur1;
    logic [SAMPLE_W-1:0]              cur2;
    logic [SAMPLE_W-1:0]              cur3;
    logic [SAMPLE_W-1:0]              cur4;
    logic [SAMPLE_W-1:0]              cur_out [N_AXES];
    logic [N_LANES-1:0][SAMPLE_W-1:0] lane_val;        // what the adcs convert
    logic [SAMPLE_W-1:0]              pot_exp [N_AXES];
    logic [SAMPLE_W-1:0]              cur_exp [N_AXES];
    logic [31:0]                      lcg_state;
    int                               errors;
    int                               checks;
    int                               tests;

    always #2 clkadc = ~clkadc;   // period 4

    ctrl_adc #(
        .CONV_CYCLES  (CONV_CYCLES),
        .FRAME_CYCLES (FRAME_CYCLES)
    ) UUT (
        .clkadc  (clkadc),
        .rst     (rst),
        .sclk    (sclk),
        .conv    (conv),
        .miso    (miso),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cur1    (cur1),
        .cur2    (cur2),
        .cur3    (cur3),
        .cur4    (cur4)
    );

    adc_model u_model (
        .sclk     (sclk),
        .conv     (conv),
        .lane_val (lane_val),
        .miso     (miso)
    );

    assign cur_out[0] = cur1;
    assign cur_out[1] = cur2;
    assign cur_out[2] = cur3;
    assign cur_out[3] = cur4;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // channel in bits 7:4 and offset in bits 3:0
    function automatic logic [ADDR_W-1:0] reg_addr(input int chan, input int off);
        return ADDR_W'((chan << 4) | off);
    endfunction

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                            output logic err);
        int n;
        @(negedge clkadc);
        psel    = 1'b1;     // setup phase
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clkadc);
        penable = 1'b1;     // access phase
        n = 0;
        @(posedge clkadc);
        while (!pready && n < APB_TIMEOUT) begin
            @(posedge clkadc);
            n++;
        end
        if (!pready) begin
            $display("APB read at %h got no pready within %0d clocks", addr, APB_TIMEOUT);
            errors++;
        end
        data = prdata;      // taken at the closing edge
        err  = pslverr;
        @(negedge clkadc);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             output logic err);
        int n;
        @(negedge clkadc);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clkadc);
        penable = 1'b1;
        n = 0;
        @(posedge clkadc);
        while (!pready && n < APB_TIMEOUT) begin
            @(posedge clkadc);
            n++;
        end
        if (!pready) begin
            $display("APB write at %h got no pready within %0d clocks", addr, APB_TIMEOUT);
            errors++;
        end
        err = pslverr;
        @(negedge clkadc);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // polls the status word until the counter moves
    task automatic wait_frame(output logic [31:0] count);
        logic [31:0] start;
        logic [31:0] now;
        logic        err;
        int          n;
        apb_read(reg_addr(0, 0), start, err);
        now = start;
        n = 0;
        while (now == start && n < FRAME_POLLS) begin
            apb_read(reg_addr(0, 0), now, err);
            n++;
        end
        if (now == start) begin
            $display("frame counter stuck at %0d, no frame completed in time", start);
            errors++;
        end
        count = now;
    endtask

    // new pot and current per axis with pot on lanes 0..3 and current on 4..7
    task automatic load_random_samples();
        logic [31:0] r;
        @(negedge clkadc);
        for (int a = 0; a < N_AXES; a++) begin
            r = next_random();
            pot_exp[a] = r[31:16];
            r = next_random();
            cur_exp[a] = r[31:16];
            lane_val[a]          = pot_exp[a];
            lane_val[N_AXES + a] = cur_exp[a];
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %-16s ok", name);
        end else begin
            $display("test %-16s %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic reset_values();
        logic [31:0] data;
        logic        err;
        int          e0;
        e0 = errors;
        apb_read(reg_addr(0, 0), data, err);   // well before the first frame lands
        check_word("status after reset", data, 32'd0);
        check_word("status pslverr", 32'(err), 32'd0);
        for (int a = 1; a <= N_AXES; a++) begin
            apb_read(reg_addr(a, 0), data, err);
            check_word($sformatf("axis %0d after reset", a), data, 32'd0);
            check_word($sformatf("axis %0d pslverr", a), 32'(err), 32'd0);
        end
        report_test("reset_values", e0);
    endtask

    task automatic sample_packing();
        logic [31:0] cnt;
        logic [31:0] data;
        logic        err;
        int          e0;
        e0 = errors;
        wait_frame(cnt);          // next conv is still ahead
        load_random_samples();
        wait_frame(cnt);          // that conv took the new values
        for (int a = 0; a < N_AXES; a++) begin
            apb_read(reg_addr(a + 1, 0), data, err);
            check_word($sformatf("axis %0d word", a + 1), data, {pot_exp[a], cur_exp[a]});
            check_word($sformatf("axis %0d pslverr", a + 1), 32'(err), 32'd0);
        end
        report_test("sample_packing", e0);
    endtask

    task automatic current_outputs();
        logic [31:0] cnt;
        int          e0;
        e0 = errors;
        load_random_samples();
        wait_frame(cnt);
        @(negedge clkadc);
        for (int a = 0; a < N_AXES; a++) begin
            check_word($sformatf("cur%0d", a + 1), 32'(cur_out[a]), 32'(cur_exp[a]));
        end
        report_test("current_outputs", e0);
    endtask

    task automatic frame_counting();
        logic [31:0] prev;
        logic [31:0] now;
        logic        err;
        int          e0;
        e0 = errors;
        apb_read(reg_addr(0, 0), prev, err);
        for (int f = 0; f < 3; f++) begin
            wait_frame(now);
            checks++;
            assert (now > prev)
            else begin
                $display("ERROR at %0t: frame counter %0d not above %0d", $time, now, prev);
                errors++;
            end
            prev = now;
        end
        report_test("frame_counting", e0);
    endtask

    // conv width, sclk rises and frame period on the adc pins
    task automatic pin_timing();
        logic sclk_prev;
        logic conv_prev;
        int   high;
        int   rises;
        int   period;
        int   n;
        int   e0;
        e0 = errors;
        n  = 0;
        @(negedge clkadc);
        while (conv != '0 && n < 2 * FRAME_CYCLES) begin   // skip a conv already running
            @(negedge clkadc);
            n++;
        end
        while (conv != '1 && n < 2 * FRAME_CYCLES) begin   // next frame start
            @(negedge clkadc);
            n++;
        end
        if (conv != '1) begin
            $display("no conv pulse on both banks within %0d clocks", 2 * FRAME_CYCLES);
            errors++;
        end else begin
            high      = 0;
            rises     = 0;
            period    = 0;
            sclk_prev = 1'b0;
            // one frame from conv rise to conv rise
            do begin
                if (conv == '1) begin
                    high++;
                end
                if (sclk == '1 && !sclk_prev) begin
                    rises++;
                end
                sclk_prev = (sclk == '1);
                conv_prev = (conv == '1);
                period++;
                @(negedge clkadc);
            end while (!(conv == '1 && !conv_prev) && period < 2 * FRAME_CYCLES);
            check_word("conv high clocks", 32'(high), 32'(CONV_CYCLES));
            check_word("sclk rises per frame", 32'(rises), 32'(SAMPLE_W));
            check_word("frame period", 32'(period), 32'(FRAME_CYCLES));
        end
        report_test("pin_timing", e0);
    endtask

    task automatic bus_errors();
        logic [31:0] data;
        logic        err;
        int          e0;
        e0 = errors;
        // writes are refused on mapped and unmapped addresses
        for (int a = 1; a <= N_AXES; a++) begin
            apb_write(reg_addr(a, 0), 32'hdead_beef ^ 32'(a), err);
            check_word($sformatf("write axis %0d pslverr", a), 32'(err), 32'd1);
            apb_read(reg_addr(a, 0), data, err);
            check_word($sformatf("axis %0d after write", a), data,
                       {pot_exp[a - 1], cur_exp[a - 1]});
        end
        apb_write(reg_addr(0, 0), 32'h0000_1234, err);
        check_word("write status pslverr", 32'(err), 32'd1);
        apb_write(reg_addr(9, 3), 32'h5555_aaaa, err);
        check_word("write unmapped pslverr", 32'(err), 32'd1);
        // unmapped reads give zero without error
        apb_read(reg_addr(5, 0), data, err);
        check_word("read channel 5", data, 32'd0);
        check_word("read channel 5 pslverr", 32'(err), 32'd0);
        apb_read(reg_addr(1, 4), data, err);
        check_word("read axis 1 offset 4", data, 32'd0);
        check_word("read axis 1 offset 4 pslverr", 32'(err), 32'd0);
        apb_read(reg_addr(0, 8), data, err);
        check_word("read status offset 8", data, 32'd0);
        report_test("bus_errors", e0);
    endtask

    // hard stop in case a wait loop misbehaves
    initial begin
        #(WATCHDOG);
        $display("run went past %0d time units, testbench stopped", WATCHDOG);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        lane_val  = '0;
        lcg_state = 32'd4974;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        repeat (RST_CYCLES) @(negedge clkadc);
        rst = 1'b0;               // first frame opens on the next edge
        reset_values();
        sample_packing();
        current_outputs();
        frame_counting();
        pin_timing();
        bus_errors();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- flist.f
src/adc_pkg.sv
src/reg_pkg.sv
src/adc_sequencer.sv
src/adc_lane_shifter.sv
src/adc_reg_file.sv
src/ctrl_adc.sv
bench/adc_model.sv
bench/ctrl_adc_checker.sv
bench/tb_ctrl_adc.sv
